/* rtl/isa_pkg.sv */
package isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_addr_t;

	typedef struct packed {
		logic [3:0] itype;
		logic [3:0] op;
		reg_addr_t ra;
		reg_addr_t rb;
		reg_addr_t rc;
		logic [10:0] imm; // low 11 bits of the 15-bit value
		logic size;
	} instr_t;

	typedef enum logic [3:0] {
		T_INH = 4'h0,
		T_CMP = 4'h3,
		T_ALU = 4'h7,
		T_LDI = 4'h8,
		T_LOAD = 4'h9,
		T_STORE = 4'ha,
		T_BRANCH = 4'hb
	} itype_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SHL,
		ALU_SHR,
		ALU_MUL // low word only
	} alu_func_e;

	typedef enum logic [1:0] {
		SRC_ALU,
		SRC_VAL,
		SRC_LOAD
	} reg_src_e;

	typedef struct packed {
		logic ltu;
		logic lt;
		logic eq;
	} ccr_t;

	typedef enum logic [2:0] {
		S_FETCH,
		S_FETCH_WAIT,
		S_DECODE,
		S_EXEC,
		S_MEM,
		S_WRITEBACK,
		S_HALT
	} state_e;

	localparam logic [3:0] OP_HALT = 4'h4;
	localparam logic [3:0] OP_CMP = 4'h0;
	localparam word_t PC_RESET = 32'h0000_0000;

endpackage

/* rtl/bus_pkg.sv */
package bus_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic we;
	} mem_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata; // empty on a write response
	} mem_rsp_t;

endpackage

/* rtl/fetch_unit.sv */
module fetch_unit import isa_pkg::*, bus_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input logic fetch_start,
	input logic redirect,
	output logic fetch_done,
	output instr_t ir,
	output mem_req_t req,
	output logic req_valid,
	input logic req_ready,
	input mem_rsp_t rsp,
	input logic rsp_valid
);
	word_t pc;
	word_t branch_offset;
	logic pending;
	logic waiting;

	// word offset relative to the next instruction
	assign branch_offset = {{15{ir.rc[3]}}, ir.rc, ir.imm, 2'b00};

	assign req.addr = pc;
	assign req.wdata = '0;
	assign req.we = 1'b0;
	assign req_valid = pending;
	assign fetch_done = waiting && rsp_valid;

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			pc <= PC_RESET;
			pending <= 1'b0;
			waiting <= 1'b0;
		end
		else
		begin
			if (fetch_start)
				pending <= 1'b1;
			else if (pending && req_ready)
			begin
				pending <= 1'b0;
				waiting <= 1'b1;
			end
			else if (fetch_done)
				waiting <= 1'b0;
			if (fetch_done)
				pc <= pc + 32'd4;
			else if (redirect)
				pc <= pc + branch_offset;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (fetch_done)
			ir <= instr_t'(rsp.rdata);
	end

endmodule

/* rtl/load_store_unit.sv */
module load_store_unit import isa_pkg::*, bus_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input logic lsu_start,
	input logic we,
	input word_t addr,
	input word_t wdata,
	output logic lsu_done,
	output word_t rdata,
	output mem_req_t req,
	output logic req_valid,
	input logic req_ready,
	input mem_rsp_t rsp,
	input logic rsp_valid
);
	mem_req_t req_q;
	logic pending; // request offered, not yet taken
	logic waiting; // accepted, response due

	assign req = req_q;
	assign req_valid = pending;
	assign lsu_done = waiting && rsp_valid;

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			pending <= 1'b0;
			waiting <= 1'b0;
		end
		else if (lsu_start)
			pending <= 1'b1;
		else if (pending && req_ready)
		begin
			pending <= 1'b0;
			waiting <= 1'b1;
		end
		else if (lsu_done)
			waiting <= 1'b0;
	end

	always_ff @(posedge clk_i)
	begin
		if (lsu_start)
			req_q <= '{addr: addr, wdata: wdata, we: we};
		if (lsu_done)
			rdata <= rsp.rdata;
	end

	a_start_idle: assert property (@(posedge clk_i) disable iff (rst_i)
		lsu_start |-> !(pending || waiting));

endmodule

/* rtl/bus_arbiter.sv */
module bus_arbiter import bus_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input mem_req_t f_req,
	input logic f_req_valid,
	output logic f_req_ready,
	output logic f_rsp_valid,
	input mem_req_t d_req,
	input logic d_req_valid,
	output logic d_req_ready,
	output logic d_rsp_valid,
	output mem_req_t mem_req,
	output logic mem_req_valid,
	input logic mem_req_ready,
	input logic mem_rsp_valid
);
	logic busy; // one transaction outstanding
	logic owner_d; // data side owns it

	assign mem_req = d_req_valid ? d_req : f_req; // data first
	assign mem_req_valid = !busy && (d_req_valid || f_req_valid);
	assign d_req_ready = !busy && mem_req_ready;
	assign f_req_ready = !busy && !d_req_valid && mem_req_ready;
	assign d_rsp_valid = mem_rsp_valid && busy && owner_d;
	assign f_rsp_valid = mem_rsp_valid && busy && !owner_d;

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			busy <= 1'b0;
			owner_d <= 1'b0;
		end
		else if (mem_req_valid && mem_req_ready)
		begin
			busy <= 1'b1;
			owner_d <= d_req_valid;
		end
		else if (mem_rsp_valid)
			busy <= 1'b0;
	end

	a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));
	a_rsp_busy: assert property (@(posedge clk_i) disable iff (rst_i)
		mem_rsp_valid |-> busy);

endmodule

/* rtl/datapath.sv */
module datapath import isa_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input instr_t ir,
	input logic operand_write,
	input logic alu_imm_sel,
	input alu_func_e alu_func,
	input logic ccr_write,
	input logic reg_write,
	input reg_src_e reg_src,
	input word_t load_data,
	output ccr_t ccr,
	output word_t mem_addr,
	output word_t store_data
);
	word_t regs [16];
	word_t a_q;
	word_t b_q;
	word_t sval;
	word_t uval;
	word_t alu_b;
	word_t alu_out;
	word_t wb_data;
	word_t ra_val;
	word_t rb_val;
	reg_addr_t b_sel;

	assign sval = {{17{ir.rc[3]}}, ir.rc, ir.imm};
	assign uval = {17'h0, ir.rc, ir.imm};
	assign ra_val = regs[ir.ra];
	assign rb_val = regs[ir.rb];
	assign b_sel = (ir.itype == T_STORE) ? ir.ra : ir.rc; // store data sits in rA
	assign alu_b = alu_imm_sel ? sval : b_q;
	assign mem_addr = a_q + sval;
	assign store_data = b_q;

	always_comb
	begin
		case (alu_func)
			ALU_ADD: alu_out = a_q + alu_b;
			ALU_SUB: alu_out = a_q - alu_b;
			ALU_AND: alu_out = a_q & alu_b;
			ALU_OR: alu_out = a_q | alu_b;
			ALU_XOR: alu_out = a_q ^ alu_b;
			ALU_SHL: alu_out = a_q << alu_b[4:0];
			ALU_SHR: alu_out = a_q >> alu_b[4:0]; // logical
			default: alu_out = a_q * alu_b;
		endcase
		case (reg_src)
			SRC_VAL: wb_data = uval;
			SRC_LOAD: wb_data = load_data;
			default: wb_data = alu_out;
		endcase
	end

	always_ff @(posedge clk_i)
	begin
		if (operand_write)
		begin
			a_q <= rb_val;
			b_q <= regs[b_sel];
		end
		if (reg_write)
			regs[ir.ra] <= wb_data;
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
			ccr <= '0;
		else if (ccr_write)
		begin
			ccr.ltu <= ra_val < rb_val;
			ccr.lt <= $signed(ra_val) < $signed(rb_val);
			ccr.eq <= ra_val == rb_val;
		end
	end

endmodule

/* rtl/control_fsm.sv */
module control_fsm import isa_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input instr_t ir,
	input ccr_t ccr,
	output logic fetch_start,
	output logic redirect,
	input logic fetch_done,
	output logic lsu_start,
	input logic lsu_done,
	output logic operand_write,
	output alu_func_e alu_func,
	output logic alu_imm_sel,
	output logic ccr_write,
	output logic reg_write,
	output reg_src_e reg_src,
	output logic halt
);
	state_e state;
	state_e state_next;
	logic taken;
	logic legal;

	assign halt = (state == S_HALT);

	always_comb
	begin
		case (ir.op)
			4'h0: taken = 1'b1; // bra
			4'h1: taken = ccr.eq; // beq
			4'h2: taken = !ccr.eq; // bne
			4'h3: taken = !(ccr.ltu || ccr.eq); // bgtu
			4'h4: taken = !(ccr.lt || ccr.eq); // bgt
			4'h5: taken = !ccr.lt; // bge
			4'h6: taken = ccr.lt || ccr.eq; // ble
			4'h7: taken = ccr.lt; // blt
			4'h8: taken = !ccr.ltu; // bgeu
			4'h9: taken = ccr.ltu; // bltu
			4'ha: taken = ccr.ltu || ccr.eq; // bleu
			default: taken = 1'b0; // brn
		endcase
	end

	always_comb
	begin
		case (ir.itype)
			T_INH: legal = (ir.op == 4'h0) || (ir.op == OP_HALT); // nop or halt
			T_CMP: legal = (ir.op == OP_CMP);
			T_ALU, T_LDI, T_BRANCH: legal = 1'b1;
			T_LOAD, T_STORE: legal = (ir.op == 4'h0); // word access only
			default: legal = 1'b0;
		endcase
		if (ir.size)
			legal = 1'b0; // no trailing argument word
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
			state <= S_FETCH;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		fetch_start = 1'b0;
		redirect = 1'b0;
		lsu_start = 1'b0;
		operand_write = 1'b0;
		ccr_write = 1'b0;
		reg_write = 1'b0;
		reg_src = SRC_ALU;
		alu_func = alu_func_e'(ir.op[2:0]);
		alu_imm_sel = ir.op[3]; // upper ops take the immediate
		case (state)
			S_FETCH:
			begin
				fetch_start = 1'b1;
				state_next = S_FETCH_WAIT;
			end
			S_FETCH_WAIT:
			begin
				if (fetch_done)
					state_next = S_DECODE;
			end
			S_DECODE:
			begin
				operand_write = 1'b1;
				state_next = legal ? S_EXEC : S_HALT;
			end
			S_EXEC:
			begin
				state_next = S_FETCH;
				case (ir.itype)
					T_INH:
					begin
						if (ir.op == OP_HALT)
							state_next = S_HALT;
					end
					T_CMP: ccr_write = 1'b1;
					T_ALU: reg_write = 1'b1;
					T_LDI:
					begin
						reg_write = 1'b1;
						reg_src = SRC_VAL;
					end
					T_LOAD, T_STORE:
					begin
						lsu_start = 1'b1;
						state_next = S_MEM;
					end
					T_BRANCH: redirect = taken;
					default: state_next = S_HALT;
				endcase
			end
			S_MEM:
			begin
				if (lsu_done)
					state_next = (ir.itype == T_LOAD) ? S_WRITEBACK : S_FETCH;
			end
			S_WRITEBACK:
			begin
				reg_write = 1'b1;
				reg_src = SRC_LOAD;
				state_next = S_FETCH;
			end
			default: state_next = S_HALT;
		endcase
	end

	a_one_unit: assert property (@(posedge clk_i) disable iff (rst_i)
		!(fetch_start && lsu_start));
	a_fetch_done_wait: assert property (@(posedge clk_i) disable iff (rst_i)
		fetch_done |-> state == S_FETCH_WAIT);
	a_lsu_done_wait: assert property (@(posedge clk_i) disable iff (rst_i)
		lsu_done |-> state == S_MEM);

endmodule

/* rtl/cpu_top.sv */
module cpu_top import isa_pkg::*, bus_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	output mem_req_t mem_req,
	output logic mem_req_valid,
	input logic mem_req_ready,
	input mem_rsp_t mem_rsp,
	input logic mem_rsp_valid,
	output logic halt
);
	instr_t ir;
	ccr_t ccr;
	logic fetch_start;
	logic redirect;
	logic fetch_done;
	logic lsu_start;
	logic lsu_done;
	logic operand_write;
	logic alu_imm_sel;
	logic ccr_write;
	logic reg_write;
	alu_func_e alu_func;
	reg_src_e reg_src;
	word_t mem_addr;
	word_t store_data;
	word_t load_data;
	mem_req_t f_req;
	mem_req_t d_req;
	logic f_req_valid;
	logic f_req_ready;
	logic f_rsp_valid;
	logic d_req_valid;
	logic d_req_ready;
	logic d_rsp_valid;

	control_fsm u_ctrl (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.ir(ir),
		.ccr(ccr),
		.fetch_start(fetch_start),
		.redirect(redirect),
		.fetch_done(fetch_done),
		.lsu_start(lsu_start),
		.lsu_done(lsu_done),
		.operand_write(operand_write),
		.alu_func(alu_func),
		.alu_imm_sel(alu_imm_sel),
		.ccr_write(ccr_write),
		.reg_write(reg_write),
		.reg_src(reg_src),
		.halt(halt)
	);

	fetch_unit u_fetch (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.fetch_start(fetch_start),
		.redirect(redirect),
		.fetch_done(fetch_done),
		.ir(ir),
		.req(f_req),
		.req_valid(f_req_valid),
		.req_ready(f_req_ready),
		.rsp(mem_rsp),
		.rsp_valid(f_rsp_valid)
	);

	load_store_unit u_lsu (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.lsu_start(lsu_start),
		.we(ir.itype == T_STORE),
		.addr(mem_addr),
		.wdata(store_data),
		.lsu_done(lsu_done),
		.rdata(load_data),
		.req(d_req),
		.req_valid(d_req_valid),
		.req_ready(d_req_ready),
		.rsp(mem_rsp), // rdata goes to both units
		.rsp_valid(d_rsp_valid)
	);

	bus_arbiter u_arb (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.f_req(f_req),
		.f_req_valid(f_req_valid),
		.f_req_ready(f_req_ready),
		.f_rsp_valid(f_rsp_valid),
		.d_req(d_req),
		.d_req_valid(d_req_valid),
		.d_req_ready(d_req_ready),
		.d_rsp_valid(d_rsp_valid),
		.mem_req(mem_req),
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_rsp_valid(mem_rsp_valid)
	);

	datapath u_dp (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.ir(ir),
		.operand_write(operand_write),
		.alu_imm_sel(alu_imm_sel),
		.alu_func(alu_func),
		.ccr_write(ccr_write),
		.reg_write(reg_write),
		.reg_src(reg_src),
		.load_data(load_data),
		.ccr(ccr),
		.mem_addr(mem_addr),
		.store_data(store_data)
	);

endmodule

/* sim/tb_cpu.sv */
module tb_cpu import isa_pkg::*, bus_pkg::*; ();
	logic clk_i;
	logic rst_i;
	mem_req_t mem_req;
	logic mem_req_valid;
	logic mem_req_ready;
	mem_rsp_t mem_rsp;
	logic mem_rsp_valid;
	logic halt;

	word_t mem [1024];
	integer seed;
	logic mem_busy;
	int rsp_wait;
	word_t rsp_word;
	logic [9:0] mem_idx;
	word_t exp_addr [$];
	word_t exp_data [$];
	logic ref_halted;
	int ref_steps;
	int next_word;
	int cycle_count;
	int data_errors;
	int proto_errors;
	int timeout_errors;
	int stores_checked;
	logic stall_q;
	mem_req_t stall_req;
	word_t want_addr;
	word_t want_data;

	cpu_top uut (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.mem_req(mem_req),
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_rsp(mem_rsp),
		.mem_rsp_valid(mem_rsp_valid),
		.halt(halt)
	);

	initial
	begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	function automatic word_t encode(logic [3:0] t, logic [3:0] op, logic [3:0] ra,
		logic [3:0] rb, logic [14:0] v);
		return {t, op, ra, rb, v, 1'b0};
	endfunction

	task automatic put_word(word_t w);
		mem[next_word] = w;
		next_word++;
	endtask

	task automatic fill_memory();
		word_t a;
		for (int i = 0; i < 1024; i++)
		begin
			a = 32'(i) << 2;
			mem[i] = 32'hd000_0000 ^ (a * 32'h0001_0003); // illegal itype d
		end
		next_word = 0;
	endtask

	// interprets the program on its own copy of memory
	function automatic void ref_run();
		word_t regs [16];
		word_t ref_mem [1024];
		word_t pc;
		word_t sval;
		word_t opa;
		word_t opb;
		word_t res;
		word_t addr;
		instr_t ins;
		ccr_t cc;
		logic take;
		logic stop;
		exp_addr.delete();
		exp_data.delete();
		ref_mem = mem;
		for (int i = 0; i < 16; i++)
			regs[i] = '0;
		pc = PC_RESET;
		cc = '0;
		stop = 1'b0;
		ref_steps = 0;
		while (!stop && ref_steps < 4096)
		begin
			ins = instr_t'(ref_mem[pc[11:2]]);
			pc = pc + 32'd4;
			ref_steps++;
			sval = {{17{ins.rc[3]}}, ins.rc, ins.imm};
			opa = regs[ins.rb];
			addr = opa + sval;
			if (ins.size)
				stop = 1'b1;
			else
				case (ins.itype)
					T_INH: stop = (ins.op != 4'h0); // halt or an unknown op
					T_CMP:
					begin
						stop = (ins.op != OP_CMP);
						cc.ltu = regs[ins.ra] < regs[ins.rb];
						cc.lt = $signed(regs[ins.ra]) < $signed(regs[ins.rb]);
						cc.eq = regs[ins.ra] == regs[ins.rb];
					end
					T_ALU:
					begin
						opb = ins.op[3] ? sval : regs[ins.rc];
						case (ins.op[2:0])
							3'd0: res = opa + opb;
							3'd1: res = opa - opb;
							3'd2: res = opa & opb;
							3'd3: res = opa | opb;
							3'd4: res = opa ^ opb;
							3'd5: res = opa << opb[4:0];
							3'd6: res = opa >> opb[4:0];
							default: res = opa * opb;
						endcase
						regs[ins.ra] = res;
					end
					T_LDI: regs[ins.ra] = {17'h0, ins.rc, ins.imm};
					T_LOAD:
					begin
						stop = (ins.op != 4'h0);
						if (!stop)
							regs[ins.ra] = ref_mem[addr[11:2]];
					end
					T_STORE:
					begin
						stop = (ins.op != 4'h0);
						if (!stop)
						begin
							ref_mem[addr[11:2]] = regs[ins.ra];
							exp_addr.push_back(addr);
							exp_data.push_back(regs[ins.ra]);
						end
					end
					T_BRANCH:
					begin
						case (ins.op)
							4'h0: take = 1'b1;
							4'h1: take = cc.eq;
							4'h2: take = !cc.eq;
							4'h3: take = !cc.ltu && !cc.eq;
							4'h4: take = !cc.lt && !cc.eq;
							4'h5: take = !cc.lt;
							4'h6: take = cc.lt || cc.eq;
							4'h7: take = cc.lt;
							4'h8: take = !cc.ltu;
							4'h9: take = cc.ltu;
							4'ha: take = cc.ltu || cc.eq;
							default: take = 1'b0;
						endcase
						if (take)
							pc = pc + {sval[29:0], 2'b00};
					end
					default: stop = 1'b1;
				endcase
		end
		ref_halted = stop;
	endfunction

	task automatic build_main_program();
		logic [3:0] pair_a [5] = '{4'd1, 4'd2, 4'd1, 4'd4, 4'd1};
		logic [3:0] pair_b [5] = '{4'd1, 4'd1, 4'd2, 4'd1, 4'd4};
		fill_memory();
		put_word(encode(T_LDI, 4'h0, 4'd15, 4'd0, 15'h0800)); // data base
		put_word(encode(T_LDI, 4'h0, 4'd1, 4'd0, 15'h1234));
		put_word(encode(T_LDI, 4'h0, 4'd2, 4'd0, 15'h0007));
		put_word(encode(T_ALU, 4'h1, 4'd4, 4'd2, {4'd1, 11'h0})); // r4 negative
		for (int f = 0; f < 8; f++)
		begin
			put_word(encode(T_ALU, {1'b0, f[2:0]}, 4'd5, 4'd1, {4'd2, 11'h0}));
			put_word(encode(T_STORE, 4'h0, 4'd5, 4'd15, 15'(f * 8)));
			put_word(encode(T_ALU, {1'b1, f[2:0]}, 4'd5, 4'd4, 15'h7ff5)); // imm -11
			put_word(encode(T_STORE, 4'h0, 4'd5, 4'd15, 15'(f * 8 + 4)));
		end
		put_word(encode(T_LDI, 4'h0, 4'd6, 4'd0, 15'h5a3c));
		put_word(encode(T_STORE, 4'h0, 4'd6, 4'd15, 15'h0040));
		put_word(encode(T_LOAD, 4'h0, 4'd7, 4'd15, 15'h0040));
		put_word(encode(T_STORE, 4'h0, 4'd7, 4'd15, 15'h0044));
		put_word(encode(T_LOAD, 4'h0, 4'd8, 4'd15, 15'h7ffc)); // below the base
		put_word(encode(T_STORE, 4'h0, 4'd8, 4'd15, 15'h0048));
		put_word(encode(T_LDI, 4'h0, 4'd10, 4'd0, 15'h00ee));
		for (int p = 0; p < 5; p++)
			for (int b = 0; b < 12; b++)
			begin
				put_word(encode(T_CMP, OP_CMP, pair_a[p], pair_b[p], 15'h0));
				put_word(encode(T_BRANCH, b[3:0], 4'd0, 4'd0, 15'd1)); // skips the marker
				put_word(encode(T_STORE, 4'h0, 4'd10, 4'd15, 15'(256 + 4 * (p * 12 + b))));
			end
		put_word(encode(T_INH, OP_HALT, 4'd0, 4'd0, 15'h0));
	endtask

	task automatic build_illegal_program();
		fill_memory();
		put_word(encode(T_LDI, 4'h0, 4'd15, 4'd0, 15'h0800));
		put_word(encode(T_LDI, 4'h0, 4'd1, 4'd0, 15'h0abc));
		put_word(encode(T_STORE, 4'h0, 4'd1, 4'd15, 15'h0000));
		put_word(encode(T_ALU, 4'h0, 4'd2, 4'd1, 15'h0) | 32'h1); // size bit set
		put_word(encode(T_STORE, 4'h0, 4'd1, 4'd15, 15'h0004));
		put_word(encode(T_INH, OP_HALT, 4'd0, 4'd0, 15'h0));
	endtask

	// memory model with random stalls and response delays
	always @(negedge clk_i)
	begin
		mem_rsp_valid = 1'b0;
		if (mem_busy)
		begin
			if (rsp_wait == 0)
			begin
				mem_rsp_valid = 1'b1;
				mem_rsp.rdata = rsp_word;
				mem_busy = 1'b0;
			end
			else
				rsp_wait = rsp_wait - 1;
		end
		mem_req_ready = ($random(seed) & 3) != 0;
		if (mem_req_valid && mem_req_ready) // transfers at the next rising edge
		begin
			mem_idx = mem_req.addr[11:2];
			if (mem_req.we)
			begin
				mem[mem_idx] = mem_req.wdata;
				rsp_word = '0;
			end
			else
				rsp_word = mem[mem_idx];
			rsp_wait = $random(seed) & 3;
			mem_busy = 1'b1;
		end
	end

	always @(posedge clk_i)
	begin
		if (rst_i)
			stall_q <= 1'b0;
		else
		begin
			if (stall_q && (!mem_req_valid || mem_req != stall_req))
			begin
				proto_errors++;
				$display("stalled request changed before it was accepted");
			end
			stall_q <= mem_req_valid && !mem_req_ready;
			stall_req <= mem_req;
			if (halt && mem_req_valid)
			begin
				proto_errors++;
				$display("request issued after halt");
			end
			if (mem_req_valid && mem_req_ready && mem_req.we)
			begin
				stores_checked++;
				if (exp_addr.size() == 0)
				begin
					data_errors++;
					$display("store to %h that the reference did not make", mem_req.addr);
				end
				else
				begin
					want_addr = exp_addr.pop_front();
					want_data = exp_data.pop_front();
					if (mem_req.addr != want_addr)
					begin
						data_errors++;
						$display("[FAIL] mem_req.addr got %h expected %h", mem_req.addr,
							want_addr);
					end
					if (mem_req.wdata != want_data)
					begin
						data_errors++;
						$display("[FAIL] mem_req.wdata got %h expected %h at %h",
							mem_req.wdata, want_data, mem_req.addr);
					end
				end
			end
		end
	end

	task automatic run_phase();
		int limit;
		int wait_count;
		@(negedge clk_i);
		rst_i = 1'b1;
		ref_run();
		if (!ref_halted)
		begin
			proto_errors++;
			$display("reference model found no halt in the program");
		end
		limit = ref_steps * 32 + 64; // worst case per instruction with stalls
		repeat (8)
		begin
			@(negedge clk_i);
			if (halt || mem_req_valid)
			begin
				proto_errors++;
				$display("halt or a request was active during reset");
			end
		end
		rst_i = 1'b0;
		wait_count = 0;
		while (!mem_req_valid && wait_count < 2)
		begin
			@(negedge clk_i);
			wait_count++;
		end
		if (!mem_req_valid)
		begin
			proto_errors++;
			$display("no fetch request within two cycles of reset release");
		end
		else if (mem_req.addr != PC_RESET || mem_req.we)
		begin
			proto_errors++;
			$display("[FAIL] mem_req.addr got %h expected %h", mem_req.addr, PC_RESET);
		end
		cycle_count = 0;
		while (!halt && cycle_count < limit)
		begin
			@(negedge clk_i);
			cycle_count++;
		end
		if (!halt)
		begin
			timeout_errors++;
			$display("timeout, no halt within %0d cycles", limit);
		end
		else
		begin
			repeat (16)
			begin
				@(negedge clk_i);
				if (!halt)
				begin
					proto_errors++;
					$display("halt dropped before reset");
				end
			end
			if (exp_addr.size() != 0)
			begin
				data_errors++;
				$display("%0d expected stores never appeared", exp_addr.size());
			end
		end
	endtask

	initial
	begin
		rst_i = 1'b1;
		mem_req_ready = 1'b0;
		mem_rsp = '0;
		mem_rsp_valid = 1'b0;
		mem_busy = 1'b0;
		rsp_wait = 0;
		rsp_word = '0;
		seed = 32'h3929;
		stall_q = 1'b0;
		data_errors = 0;
		proto_errors = 0;
		timeout_errors = 0;
		stores_checked = 0;
		build_main_program();
		run_phase();
		if (timeout_errors == 0)
		begin
			build_illegal_program();
			run_phase();
		end
		$display("errors: data %0d, protocol %0d, timeout %0d (%0d stores checked)",
			data_errors, proto_errors, timeout_errors, stores_checked);
		if (data_errors == 0 && proto_errors == 0 && timeout_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* project.f */
rtl/isa_pkg.sv
rtl/bus_pkg.sv
rtl/fetch_unit.sv
rtl/load_store_unit.sv
rtl/bus_arbiter.sv
rtl/datapath.sv
rtl/control_fsm.sv
rtl/cpu_top.sv
sim/tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_cpu
LINT_TOP ?= cpu_top
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG ?= TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)
